/* verilog/glm_wb_pkg.sv */
`default_nettype none

package glm_wb_pkg;

    // Line and word geometry
    localparam int LINE_BITS      = 512;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;
    localparam int ADDR_BITS      = 42;                         // Host cache-line address

    // Scratchpad layout
    localparam int SP_LINES         = 256;
    localparam int SP_ADDR_BITS     = 8;
    localparam int REGION_LINES     = 128;                      // Labels start at this line
    localparam int REGION_ADDR_BITS = $clog2(REGION_LINES);

    // Reader line buffer
    localparam int BUF_DEPTH    = 4;
    localparam int BUF_PTR_BITS = $clog2(BUF_DEPTH);
    localparam int BUF_CNT_BITS = $clog2(BUF_DEPTH + 1);       // Holds 0 to BUF_DEPTH

    typedef enum logic [0:0]
    {
        REGION_MODEL,
        REGION_LABELS
    } region_t;

    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_PREPROCESS,
        WR_WRITE,
        WR_DONE
    } writer_state_t;

    // Control register fields
    localparam int CTRL_REGION_BIT = 0;
    localparam int CTRL_FENCE_BIT  = 4;
    localparam int CTRL_SYNTH_BIT  = 5;

    // Store register: top bit picks in_addr over out_addr
    localparam int STORE_SEL_BIT = 31;

endpackage

`default_nettype wire

/* verilog/scratchpad_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module scratchpad_ram
(
    input  logic                                clk,
    input  logic                                en,
    input  logic                                we,
    input  logic [glm_wb_pkg::SP_ADDR_BITS-1:0] addr,
    input  logic [glm_wb_pkg::LINE_BITS-1:0]    wdata,
    output logic [glm_wb_pkg::LINE_BITS-1:0]    rdata
);

    logic [glm_wb_pkg::LINE_BITS-1:0] mem [glm_wb_pkg::SP_LINES];

    // Writes and reads share one port, rdata holds between reads
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
            begin
                mem[addr] <= wdata;
            end
            else
            begin
                rdata <= mem[addr];                             // One-cycle read latency
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/scratchpad_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module scratchpad_arbiter
(
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                load_valid,
    input  logic [glm_wb_pkg::SP_ADDR_BITS-1:0] load_addr,
    input  logic [glm_wb_pkg::LINE_BITS-1:0]    load_data,

    input  logic                                fetch_req,
    input  logic [glm_wb_pkg::SP_ADDR_BITS-1:0] fetch_addr,
    output logic                                fetch_grant,
    output logic [glm_wb_pkg::LINE_BITS-1:0]    fetch_data,
    output logic                                fetch_data_valid
);

    logic                                ram_en;
    logic                                ram_we;
    logic [glm_wb_pkg::SP_ADDR_BITS-1:0] ram_addr;
    logic                                read_pending;

    assign fetch_grant = fetch_req && !load_valid;              // Loader always wins
    assign ram_en      = load_valid || fetch_grant;
    assign ram_we      = load_valid;
    assign ram_addr    = load_valid ? load_addr : fetch_addr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_pending <= 1'b0;
        end
        else
        begin
            read_pending <= fetch_grant;                        // Data arrives next cycle
        end
    end

    assign fetch_data_valid = read_pending;

    scratchpad_ram ram_inst
    (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (load_data),
        .rdata (fetch_data)
    );

    // A grant never collides with a load
    a_grant_no_load: assert property (@(posedge clk) disable iff (reset)
        fetch_grant |-> !load_valid);

endmodule

`default_nettype wire

/* verilog/region_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module region_reader
(
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                op_start,
    input  logic [31:0]                         reg_length,
    input  logic [7:0]                          reg_control,

    output logic                                fetch_req,
    output logic [glm_wb_pkg::SP_ADDR_BITS-1:0] fetch_addr,
    input  logic                                fetch_grant,
    input  logic [glm_wb_pkg::LINE_BITS-1:0]    fetch_data,
    input  logic                                fetch_data_valid,

    output logic                                buf_valid,
    output logic [glm_wb_pkg::LINE_BITS-1:0]    buf_data,
    input  logic                                buf_pop
);

    glm_wb_pkg::region_t                      region_q;
    logic [31:0]                              length_q;
    logic [31:0]                              req_count;       // Lines requested so far
    logic [glm_wb_pkg::SP_ADDR_BITS-1:0]      region_base;

    logic [glm_wb_pkg::LINE_BITS-1:0]         buf_mem [glm_wb_pkg::BUF_DEPTH];
    logic [glm_wb_pkg::BUF_PTR_BITS-1:0]      wr_ptr;
    logic [glm_wb_pkg::BUF_PTR_BITS-1:0]      rd_ptr;
    logic [glm_wb_pkg::BUF_CNT_BITS-1:0]      fill_count;      // Lines held in the buffer
    logic [glm_wb_pkg::BUF_CNT_BITS-1:0]      occ_count;       // Held plus in flight
    logic                                     fetch_taken;

    assign region_base = (region_q == glm_wb_pkg::REGION_LABELS) ?
                         glm_wb_pkg::SP_ADDR_BITS'(glm_wb_pkg::REGION_LINES) : '0;

    // Index truncated to the region size so the address wraps inside it
    assign fetch_addr = region_base +
                        glm_wb_pkg::SP_ADDR_BITS'(req_count[glm_wb_pkg::REGION_ADDR_BITS-1:0]);

    assign fetch_req = (req_count != length_q) &&
                       (occ_count < glm_wb_pkg::BUF_CNT_BITS'(glm_wb_pkg::BUF_DEPTH));
    assign fetch_taken = fetch_req && fetch_grant;

    assign buf_valid = (fill_count != '0);
    assign buf_data  = buf_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            region_q   <= glm_wb_pkg::REGION_MODEL;
            length_q   <= '0;
            req_count  <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
            occ_count  <= '0;
        end
        else
        begin
            if (op_start)
            begin
                region_q  <= glm_wb_pkg::region_t'(reg_control[glm_wb_pkg::CTRL_REGION_BIT]);
                length_q  <= reg_length;
                req_count <= '0;
            end
            else if (fetch_taken)
            begin
                req_count <= req_count + 32'd1;
            end

            if (fetch_data_valid)
            begin
                wr_ptr <= wr_ptr + glm_wb_pkg::BUF_PTR_BITS'(1);
            end
            if (buf_pop)
            begin
                rd_ptr <= rd_ptr + glm_wb_pkg::BUF_PTR_BITS'(1);
            end

            fill_count <= fill_count + glm_wb_pkg::BUF_CNT_BITS'(fetch_data_valid)
                                     - glm_wb_pkg::BUF_CNT_BITS'(buf_pop);
            occ_count  <= occ_count + glm_wb_pkg::BUF_CNT_BITS'(fetch_taken)
                                    - glm_wb_pkg::BUF_CNT_BITS'(buf_pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_data_valid)
        begin
            buf_mem[wr_ptr] <= fetch_data;
        end
    end

    a_pop_needs_data: assert property (@(posedge clk) disable iff (reset)
        buf_pop |-> buf_valid);

    // In-flight fetches are counted too, so a full buffer is never overrun
    a_occ_bound: assert property (@(posedge clk) disable iff (reset)
        occ_count <= glm_wb_pkg::BUF_CNT_BITS'(glm_wb_pkg::BUF_DEPTH));

endmodule

`default_nettype wire

/* verilog/line_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module line_writer
(
    input  logic                             clk,
    input  logic                             reset,

    input  logic                             op_start,
    input  logic [31:0]                      reg_offset_0,
    input  logic [31:0]                      reg_offset_1,
    input  logic [31:0]                      reg_offset_2,
    input  logic [31:0]                      reg_store,
    input  logic [31:0]                      reg_length,
    input  logic [7:0]                       reg_control,
    input  logic [glm_wb_pkg::ADDR_BITS-1:0] in_addr,
    input  logic [glm_wb_pkg::ADDR_BITS-1:0] out_addr,

    input  logic                             buf_valid,
    input  logic [glm_wb_pkg::LINE_BITS-1:0] buf_data,
    output logic                             buf_pop,

    output logic                             tx_valid,
    output logic [glm_wb_pkg::ADDR_BITS-1:0] tx_addr,
    output logic [glm_wb_pkg::LINE_BITS-1:0] tx_data,
    input  logic                             tx_almost_full,
    input  logic                             rsp_valid,

    output logic                             op_done
);

    glm_wb_pkg::writer_state_t        state;

    logic [31:0]                      offset_q [3];             // Shifted down each preprocess
    logic [glm_wb_pkg::ADDR_BITS-1:0] store_addr;
    logic [glm_wb_pkg::ADDR_BITS-1:0] store_base;
    logic [31:0]                      length_q;
    logic                             fence_q;
    logic                             synth_q;

    logic [1:0]                       offset_sel;
    logic [31:0]                      sent_count;
    logic [31:0]                      ack_count;

    assign store_base = reg_store[glm_wb_pkg::STORE_SEL_BIT] ? in_addr : out_addr;

    // Pop only what the operation still needs
    assign buf_pop = (state == glm_wb_pkg::WR_WRITE) && buf_valid && !tx_almost_full &&
                     (sent_count != length_q);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= glm_wb_pkg::WR_IDLE;
            offset_sel <= '0;
            sent_count <= '0;
            ack_count  <= '0;
            tx_valid   <= 1'b0;
            op_done    <= 1'b0;
        end
        else
        begin
            tx_valid <= buf_pop;                                // Request one cycle after pop
            op_done  <= 1'b0;

            case (state)
                glm_wb_pkg::WR_IDLE:
                begin
                    if (op_start)
                    begin
                        offset_sel <= '0;
                        sent_count <= '0;
                        ack_count  <= '0;
                        state      <= (reg_length == 32'd0) ? glm_wb_pkg::WR_DONE
                                                            : glm_wb_pkg::WR_PREPROCESS;
                    end
                end

                glm_wb_pkg::WR_PREPROCESS:
                begin
                    offset_sel <= offset_sel + 2'd1;
                    if (offset_sel == 2'd2)
                    begin
                        state <= glm_wb_pkg::WR_WRITE;
                    end
                end

                glm_wb_pkg::WR_WRITE:
                begin
                    if (buf_pop)
                    begin
                        sent_count <= sent_count + 32'd1;
                        if (sent_count == length_q - 32'd1 && !fence_q)
                        begin
                            state <= glm_wb_pkg::WR_DONE;        // Done follows last request
                        end
                    end

                    if (rsp_valid)
                    begin
                        ack_count <= ack_count + 32'd1;
                        if (ack_count == length_q - 32'd1 && fence_q)
                        begin
                            op_done <= 1'b1;                    // Fence: right after last ack
                            state   <= glm_wb_pkg::WR_IDLE;
                        end
                    end
                end

                glm_wb_pkg::WR_DONE:
                begin
                    op_done <= 1'b1;
                    state   <= glm_wb_pkg::WR_IDLE;
                end

                default:
                begin
                    state <= glm_wb_pkg::WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == glm_wb_pkg::WR_IDLE && op_start)
        begin
            offset_q[0] <= reg_offset_0;
            offset_q[1] <= reg_offset_1;
            offset_q[2] <= reg_offset_2;
            store_addr  <= store_base +
                           glm_wb_pkg::ADDR_BITS'(reg_store[glm_wb_pkg::STORE_SEL_BIT-1:0]);
            length_q    <= reg_length;
            fence_q     <= reg_control[glm_wb_pkg::CTRL_FENCE_BIT];
            synth_q     <= reg_control[glm_wb_pkg::CTRL_SYNTH_BIT];
        end
        else if (state == glm_wb_pkg::WR_PREPROCESS)
        begin
            store_addr  <= store_addr + glm_wb_pkg::ADDR_BITS'(offset_q[0]);
            offset_q[0] <= offset_q[1];
            offset_q[1] <= offset_q[2];
        end

        if (buf_pop)
        begin
            tx_addr <= store_addr + glm_wb_pkg::ADDR_BITS'(sent_count);
            if (synth_q)
            begin
                tx_data <= {glm_wb_pkg::WORDS_PER_LINE{sent_count[glm_wb_pkg::WORD_BITS-1:0]}};
            end
            else
            begin
                tx_data <= buf_data;
            end
        end
    end

    // Back-pressure is honoured: a request never follows an almost-full cycle
    a_tx_after_room: assert property (@(posedge clk) disable iff (reset)
        tx_valid |-> !$past(tx_almost_full));

endmodule

`default_nettype wire

/* verilog/glm_writeback_top.sv */
`timescale 1ns/1ns
`default_nettype none

module glm_writeback_top
(
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                op_start,
    output logic                                op_done,

    input  logic [31:0]                         reg_offset_0,
    input  logic [31:0]                         reg_offset_1,
    input  logic [31:0]                         reg_offset_2,
    input  logic [31:0]                         reg_store,
    input  logic [31:0]                         reg_length,
    input  logic [7:0]                          reg_control,
    input  logic [glm_wb_pkg::ADDR_BITS-1:0]    in_addr,
    input  logic [glm_wb_pkg::ADDR_BITS-1:0]    out_addr,

    input  logic                                load_valid,
    input  logic [glm_wb_pkg::SP_ADDR_BITS-1:0] load_addr,
    input  logic [glm_wb_pkg::LINE_BITS-1:0]    load_data,

    output logic                                tx_valid,
    output logic [glm_wb_pkg::ADDR_BITS-1:0]    tx_addr,
    output logic [glm_wb_pkg::LINE_BITS-1:0]    tx_data,
    input  logic                                tx_almost_full,
    input  logic                                rsp_valid
);

    logic                                fetch_req;
    logic [glm_wb_pkg::SP_ADDR_BITS-1:0] fetch_addr;
    logic                                fetch_grant;
    logic [glm_wb_pkg::LINE_BITS-1:0]    fetch_data;
    logic                                fetch_data_valid;
    logic                                buf_valid;
    logic [glm_wb_pkg::LINE_BITS-1:0]    buf_data;
    logic                                buf_pop;

    scratchpad_arbiter arbiter_inst
    (
        .clk, .reset,
        .load_valid, .load_addr, .load_data,
        .fetch_req, .fetch_addr, .fetch_grant,
        .fetch_data, .fetch_data_valid
    );

    region_reader reader_inst
    (
        .clk, .reset,
        .op_start, .reg_length, .reg_control,
        .fetch_req, .fetch_addr, .fetch_grant,
        .fetch_data, .fetch_data_valid,
        .buf_valid, .buf_data, .buf_pop
    );

    line_writer writer_inst
    (
        .clk, .reset,
        .op_start,
        .reg_offset_0, .reg_offset_1, .reg_offset_2,
        .reg_store, .reg_length, .reg_control,
        .in_addr, .out_addr,
        .buf_valid, .buf_data, .buf_pop,
        .tx_valid, .tx_addr, .tx_data,
        .tx_almost_full, .rsp_valid,
        .op_done
    );

endmodule

`default_nettype wire

/* sim/glm_writeback_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module glm_writeback_tb;

    localparam int LINE            = glm_wb_pkg::LINE_BITS;
    localparam int ABITS           = glm_wb_pkg::ADDR_BITS;
    localparam int RLINES          = glm_wb_pkg::REGION_LINES;
    localparam int NUM_OPS         = 16;
    localparam int WATCHDOG_CYCLES = NUM_OPS * (RLINES + 64) * 4;

    logic                                clk            = 1'b0;
    logic                                reset          = 1'b1;
    logic                                op_start       = 1'b0;
    logic                                op_done;
    logic [31:0]                         reg_offset_0   = '0;
    logic [31:0]                         reg_offset_1   = '0;
    logic [31:0]                         reg_offset_2   = '0;
    logic [31:0]                         reg_store      = '0;
    logic [31:0]                         reg_length     = '0;
    logic [7:0]                          reg_control    = '0;
    logic [ABITS-1:0]                    in_addr        = '0;
    logic [ABITS-1:0]                    out_addr       = '0;
    logic                                load_valid     = 1'b0;
    logic [glm_wb_pkg::SP_ADDR_BITS-1:0] load_addr      = '0;
    logic [LINE-1:0]                     load_data      = '0;
    logic                                tx_valid;
    logic [ABITS-1:0]                    tx_addr;
    logic [LINE-1:0]                     tx_data;
    logic                                tx_almost_full = 1'b0;
    logic                                rsp_valid      = 1'b0;

    logic [31:0]      rng_state = 32'd72387;
    logic [LINE-1:0]  sp_model [glm_wb_pkg::SP_LINES];  // Copy of the scratchpad
    logic [ABITS-1:0] cur_addr0;                        // Host address of line 0
    logic             cur_region;
    logic             cur_fence;
    logic             cur_synth;
    int               cur_len;
    int               cycle = 0;
    int               tx_count = 0;
    int               acks_returned = 0;
    int               pending_acks = 0;                 // Requests not yet acknowledged
    int               start_cycle = 0;
    int               last_tx_cycle = 0;
    int               last_ack_cycle = 0;
    bit               op_active = 1'b0;
    bit               done_seen = 1'b0;
    bit               af_prev = 1'b0;                   // Almost-full one cycle back

    glm_writeback_top uut
    (
        .clk, .reset, .op_start, .op_done,
        .reg_offset_0, .reg_offset_1, .reg_offset_2,
        .reg_store, .reg_length, .reg_control, .in_addr, .out_addr,
        .load_valid, .load_addr, .load_data,
        .tx_valid, .tx_addr, .tx_data, .tx_almost_full, .rsp_valid
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [LINE-1:0] random_line();
        logic [LINE-1:0] line;
        for (int w = 0; w < glm_wb_pkg::WORDS_PER_LINE; w++)
        begin
            line[w*32 +: 32] = xorshift32();
        end
        return line;
    endfunction

    function automatic logic [ABITS-1:0] random_addr();
        logic [63:0] wide;
        wide = {xorshift32(), xorshift32()};
        return wide[ABITS-1:0];
    endfunction

    // Synthetic lines repeat their index, others come from the read region
    function automatic logic [LINE-1:0] expected_line(input int idx);
        if (cur_synth)
        begin
            return {glm_wb_pkg::WORDS_PER_LINE{32'(idx)}};
        end
        return sp_model[int'(cur_region) * RLINES + idx];
    endfunction

    task automatic check_value(input logic [LINE-1:0] actual, input logic [LINE-1:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic check_completion();
        check_value(LINE'(op_active), LINE'(1), "done without an operation");
        check_value(LINE'(tx_count), LINE'(cur_len), "request count at done");
        if (cur_len == 0)
        begin
            check_value(LINE'(cycle - start_cycle), LINE'(2), "zero-length done delay");
        end
        else if (cur_fence)
        begin
            check_value(LINE'(acks_returned), LINE'(cur_len), "acks before fenced done");
            check_value(LINE'(cycle - last_ack_cycle), LINE'(1), "fenced done delay");
        end
        else
        begin
            check_value(LINE'(cycle - last_tx_cycle), LINE'(1), "done delay after last request");
        end
        op_active = 1'b0;
        done_seen = 1'b1;
    endtask

    // Host side, sampled mid-cycle
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (op_start)
            begin
                start_cycle = cycle;
            end
            if (tx_valid)
            begin
                check_value(LINE'(op_active), LINE'(1), "request outside an operation");
                check_value(LINE'(af_prev), LINE'(0), "request after an almost-full cycle");
                check_value(LINE'(tx_addr), LINE'(cur_addr0 + ABITS'(tx_count)),
                            $sformatf("address of request %0d", tx_count));
                check_value(tx_data, expected_line(tx_count),
                            $sformatf("data of request %0d", tx_count));
                tx_count = tx_count + 1;
                pending_acks = pending_acks + 1;
                last_tx_cycle = cycle;
            end
            if (rsp_valid)
            begin
                acks_returned = acks_returned + 1;
                last_ack_cycle = cycle;
            end
            if (op_done)
            begin
                check_completion();
            end
            af_prev = tx_almost_full;
        end
    end

    task automatic drive_cycle(input bit loads_on);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = xorshift32();
        tx_almost_full = (r[1:0] == 2'b00);
        rsp_valid = (pending_acks != 0) && (r[3:2] != 2'b00);
        if (rsp_valid)
        begin
            pending_acks = pending_acks - 1;
        end
        load_valid = loads_on && (r[6:4] == 3'b000);
        if (load_valid)
        begin
            load_addr = {~cur_region, r[13:7]};         // Only the region not being read
            load_data = random_line();
            sp_model[load_addr] = load_data;
        end
    endtask

    task automatic fill_scratchpad();
        logic [LINE-1:0] line;
        for (int a = 0; a < glm_wb_pkg::SP_LINES; a++)
        begin
            @(posedge clk);
            #1;
            line = random_line();
            load_valid = 1'b1;
            load_addr = 8'(a);
            load_data = line;
            sp_model[a] = line;
            rsp_valid = 1'b0;
        end
    endtask

    task automatic run_operation(input int k);
        logic [ABITS-1:0] base;
        while (pending_acks != 0)
        begin
            drive_cycle(1'b0);                          // Drain acks of the last operation
        end
        fill_scratchpad();
        cur_region = k[0];
        cur_fence = k[2];
        cur_synth = k[3];
        if (k % 7 == 0)
        begin
            cur_len = 0;
        end
        else if (k == 5)
        begin
            cur_len = RLINES;
        end
        else
        begin
            cur_len = 1 + int'(xorshift32() % 32'(RLINES));
        end
        reg_offset_0 = xorshift32();
        reg_offset_1 = xorshift32();
        reg_offset_2 = xorshift32();
        reg_store = xorshift32();
        reg_store[glm_wb_pkg::STORE_SEL_BIT] = k[1];
        reg_length = 32'(cur_len);
        reg_control = 8'(xorshift32());                 // Unused bits stay random
        reg_control[glm_wb_pkg::CTRL_REGION_BIT] = cur_region;
        reg_control[glm_wb_pkg::CTRL_FENCE_BIT] = cur_fence;
        reg_control[glm_wb_pkg::CTRL_SYNTH_BIT] = cur_synth;
        in_addr = random_addr();
        out_addr = random_addr();
        base = k[1] ? in_addr : out_addr;
        cur_addr0 = base + ABITS'(reg_store[30:0]) + ABITS'(reg_offset_0) +
                    ABITS'(reg_offset_1) + ABITS'(reg_offset_2);
        drive_cycle(1'b1);
        tx_count = 0;
        acks_returned = 0;
        op_active = 1'b1;
        done_seen = 1'b0;
        op_start = 1'b1;
        while (!done_seen)
        begin
            drive_cycle(1'b1);
            op_start = 1'b0;
        end
    endtask

    initial
    begin
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int k = 0; k < NUM_OPS; k++)
        begin
            run_operation(k);
        end
        $display("** PASS **");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the operations did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* glm_writeback_top.f */
verilog/glm_wb_pkg.sv
verilog/scratchpad_ram.sv
verilog/scratchpad_arbiter.sv
verilog/region_reader.sv
verilog/line_writer.sv
verilog/glm_writeback_top.sv
sim/glm_writeback_tb.sv

/* Makefile */
FILES = glm_writeback_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module glm_writeback_top -f $(FILES)

sim:
	verilator --binary --timing --top-module glm_writeback_tb -f $(FILES)
	./obj_dir/Vglm_writeback_tb | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir
